// ==== design/gpio_macros.svh ====
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// Pins per port, one byte lane holds a whole register so at most 8
`define GPIO_PINS 8

// Ports A to D
`define GPIO_NUM_PORTS 4

// Mode, direction, output and input
`define GPIO_REGS_PER_PORT 4

// PADDR bits taken into the decode, the rest are ignored
`define GPIO_ADDR_BITS 16

`endif

// ==== design/gpio_pkg.sv ====
`default_nettype none

`include "gpio_macros.svh"

package gpio_pkg;

    // One APB data word, seen whole or as its four byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;     // bytes[0] is PWDATA[7:0]
    } apbWordT;

    // Register offset inside a port
    typedef enum logic [$clog2(`GPIO_REGS_PER_PORT)-1:0] {
        MODE,                       // 0 push-pull, 1 open-drain
        DIRECTION,                  // 1 is output
        OUTPUT,
        INPUT                       // Read only
    } regSelT;

endpackage

`default_nettype wire

// ==== design/apbRegControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_macros.svh"

module apbRegControl (
    input  wire logic                                       PSEL,
    input  wire logic                                       PENABLE,
    input  wire logic                                       PWRITE,
    input  wire logic [31:0]                                PADDR,
    input  wire logic [31:0]                                PWDATA,
    input  wire logic [3:0]                                 PSTRB,
    input  wire logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] rdByte,
    output logic      [31:0]                                PRDATA,
    output logic                                            PSLVERR,
    output logic      [`GPIO_NUM_PORTS-1:0]                 portWrEn,
    output gpio_pkg::regSelT                                regSel,
    output logic      [`GPIO_PINS-1:0]                      wrByte
);
    import gpio_pkg::*;

    localparam int regBits  = $clog2(`GPIO_REGS_PER_PORT);
    localparam int portBits = $clog2(`GPIO_NUM_PORTS);
    localparam int mapBits  = regBits + portBits;

    logic                access;
    logic                mapped;
    logic [portBits-1:0] portIdx;
    logic                wrInputErr;
    logic                slvErr;
    logic                strbOneHot;
    logic [1:0]          laneSel;
    logic [7:0]          laneByte;
    logic                wrAllowed;
    apbWordT             wrWord;
    apbWordT             rdWord;

    assign access  = PSEL & PENABLE;                         // Access phase
    assign mapped  = ~|PADDR[`GPIO_ADDR_BITS-1:mapBits];     // Offsets 0 to 15 only
    assign portIdx = PADDR[mapBits-1:regBits];
    assign regSel  = regSelT'(PADDR[regBits-1:0]);

    assign wrInputErr = PWRITE && (regSel == INPUT);
    assign slvErr     = access && (!mapped || wrInputErr);
    assign PSLVERR    = slvErr;

    // Only a single active strobe selects a lane
    always_comb
    begin
        strbOneHot = 1'b1;
        laneSel    = 2'd0;
        case (PSTRB)
            4'b0001: laneSel = 2'd0;
            4'b0010: laneSel = 2'd1;
            4'b0100: laneSel = 2'd2;
            4'b1000: laneSel = 2'd3;
            default: strbOneHot = 1'b0;
        endcase
    end

    assign wrWord   = apbWordT'(PWDATA);
    assign laneByte = wrWord.bytes[laneSel];
    assign wrByte   = laneByte[`GPIO_PINS-1:0];

    // Bad strobes are dropped without an error
    assign wrAllowed = access && PWRITE && mapped && (regSel != INPUT) && strbOneHot;

    always_comb
    begin
        for (int i = 0; i < `GPIO_NUM_PORTS; i++)
        begin
            portWrEn[i] = wrAllowed && (portIdx == portBits'(i));
        end
    end

    always_comb
    begin
        rdWord.word     = '0;
        rdWord.bytes[0] = 8'(rdByte[portIdx]);              // Register in byte 0
        if (access && !PWRITE && !slvErr)
        begin
            PRDATA = rdWord.word;
        end
        else
        begin
            PRDATA = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/gpioPortBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_macros.svh"

module gpioPortBank (
    input  wire logic                   PCLK,
    input  wire logic                   PRESETn,
    input  wire logic                   wrEn,
    input  wire gpio_pkg::regSelT       regSel,
    input  wire logic [`GPIO_PINS-1:0]  wrByte,
    input  wire logic [`GPIO_PINS-1:0]  padIn,
    output logic      [`GPIO_PINS-1:0]  rdByte,
    output logic      [`GPIO_PINS-1:0]  padOut,
    output logic      [`GPIO_PINS-1:0]  padOutEn
);
    import gpio_pkg::*;

    logic [`GPIO_PINS-1:0] modeReg;     // Set bit is open-drain
    logic [`GPIO_PINS-1:0] dirReg;      // Set bit is output
    logic [`GPIO_PINS-1:0] outReg;
    logic [`GPIO_PINS-1:0] syncStage;   // First synchronizer flop
    logic [`GPIO_PINS-1:0] inReg;       // Second flop, read as INPUT

    always_ff @(posedge PCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            modeReg <= '0;
            dirReg  <= '0;
            outReg  <= '0;
        end
        else if (wrEn)
        begin
            case (regSel)
                MODE:      modeReg <= wrByte;
                DIRECTION: dirReg  <= wrByte;
                OUTPUT:    outReg  <= wrByte;
                default:   ;                    // Input register has no write path
            endcase
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            syncStage <= '0;
            inReg     <= '0;
        end
        else
        begin
            syncStage <= padIn;
            inReg     <= syncStage;
        end
    end

    // Open-drain pins only ever pull low, and release when the output bit is 1
    always_ff @(posedge PCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            padOut   <= '0;
            padOutEn <= '0;
        end
        else
        begin
            padOut   <= outReg & ~modeReg;
            padOutEn <= dirReg & ~(modeReg & outReg);
        end
    end

    always_comb
    begin
        case (regSel)
            MODE:      rdByte = modeReg;
            DIRECTION: rdByte = dirReg;
            OUTPUT:    rdByte = outReg;
            default:   rdByte = inReg;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/gpioController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_macros.svh"

module gpioController (
    input  wire logic                   PCLK,
    input  wire logic                   PRESETn,
    input  wire logic                   PSEL,
    input  wire logic                   PENABLE,
    input  wire logic                   PWRITE,
    input  wire logic [31:0]            PADDR,
    input  wire logic [31:0]            PWDATA,
    input  wire logic [3:0]             PSTRB,
    output logic      [31:0]            PRDATA,
    output logic                        PREADY,
    output logic                        PSLVERR,

    output logic      [`GPIO_PINS-1:0]  padOutA,
    output logic      [`GPIO_PINS-1:0]  padOutB,
    output logic      [`GPIO_PINS-1:0]  padOutC,
    output logic      [`GPIO_PINS-1:0]  padOutD,
    output logic      [`GPIO_PINS-1:0]  padOutEnA,
    output logic      [`GPIO_PINS-1:0]  padOutEnB,
    output logic      [`GPIO_PINS-1:0]  padOutEnC,
    output logic      [`GPIO_PINS-1:0]  padOutEnD,
    input  wire logic [`GPIO_PINS-1:0]  padInA,
    input  wire logic [`GPIO_PINS-1:0]  padInB,
    input  wire logic [`GPIO_PINS-1:0]  padInC,
    input  wire logic [`GPIO_PINS-1:0]  padInD
);
    import gpio_pkg::*;

    logic [`GPIO_NUM_PORTS-1:0]                 portWrEn;
    regSelT                                     regSel;
    logic [`GPIO_PINS-1:0]                      wrByte;
    logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] rdByte;
    logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] padOutAll;
    logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] padOutEnAll;
    logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] padInAll;

    assign PREADY = 1'b1;                       // Zero wait states

    apbRegControl uApbRegControl (
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PWRITE   (PWRITE),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PSTRB    (PSTRB),
        .rdByte   (rdByte),
        .PRDATA   (PRDATA),
        .PSLVERR  (PSLVERR),
        .portWrEn (portWrEn),
        .regSel   (regSel),
        .wrByte   (wrByte)
    );

    for (genvar i = 0; i < `GPIO_NUM_PORTS; i++)
    begin : genBank
        gpioPortBank uPortBank (
            .PCLK     (PCLK),
            .PRESETn  (PRESETn),
            .wrEn     (portWrEn[i]),
            .regSel   (regSel),
            .wrByte   (wrByte),
            .padIn    (padInAll[i]),
            .rdByte   (rdByte[i]),
            .padOut   (padOutAll[i]),
            .padOutEn (padOutEnAll[i])
        );
    end

    assign padInAll = {padInD, padInC, padInB, padInA};   // Port A is bank 0

    assign padOutA   = padOutAll[0];
    assign padOutB   = padOutAll[1];
    assign padOutC   = padOutAll[2];
    assign padOutD   = padOutAll[3];
    assign padOutEnA = padOutEnAll[0];
    assign padOutEnB = padOutEnAll[1];
    assign padOutEnC = padOutEnAll[2];
    assign padOutEnD = padOutEnAll[3];

endmodule

`default_nettype wire

// ==== sim/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic PCLK,
    output logic PRESETn
);

    initial
    begin
        PCLK = 1'b0;
        forever #2 PCLK = ~PCLK;        // 4 ns period
    end

    initial
    begin
        PRESETn <= 1'b0;
        repeat (2) @(posedge PCLK);
        PRESETn <= 1'b1;                // Released on a rising edge
    end

endmodule

`default_nettype wire

// ==== sim/gpioController_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_macros.svh"

module gpioController_sva (
    input  wire logic                                       PCLK,
    input  wire logic                                       PRESETn,
    input  wire logic                                       PSEL,
    input  wire logic                                       PENABLE,
    input  wire logic                                       PSLVERR,
    input  wire logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] padOutAll,
    input  wire logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] padOutEnAll,
    input  wire logic [`GPIO_NUM_PORTS-1:0][`GPIO_PINS-1:0] modeAll
);

    errOnlyInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !(PSEL && PENABLE) |-> !PSLVERR)
        else $error("PSLVERR high outside an access cycle");

    padsReleasedAfterReset: assert property (@(posedge PCLK)
        $rose(PRESETn) |-> (padOutEnAll == '0))
        else $error("Pad output enable set at the first edge after reset");

    // Pad drive is registered, so it follows the mode of the edge before
    openDrainNeverHigh: assert property (@(posedge PCLK) disable iff (!PRESETn)
        ((padOutEnAll & padOutAll & $past(modeAll)) == '0))
        else $error("Open-drain pin enabled while driving high");

endmodule

`default_nettype wire

// ==== sim/gpioController_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_macros.svh"

module gpioController_tb;
    import gpio_pkg::*;

    localparam int idleCycles   = 2;
    localparam int readyTimeout = 16;
    localparam int resetTimeout = 32;

    typedef enum logic [1:0] {WR, RD, SET_EXT, CHK_PADS} opKindT;

    typedef struct packed {
        opKindT      kind;
        logic [31:0] addr;      // Word offset, port index for pad ops
        logic [3:0]  strb;
        logic [31:0] data;      // Care mask for CHK_PADS
        logic [7:0]  expByte;   // Read byte, padOutEn for CHK_PADS
        logic [7:0]  expPad;
        logic        expErr;
    } opT;

    opT opTable[$];

    logic            PCLK;
    logic            PRESETn;
    logic            PSEL;
    logic            PENABLE;
    logic            PWRITE;
    logic [31:0]     PADDR;
    logic [31:0]     PWDATA;
    logic [3:0]      PSTRB;
    logic [31:0]     PRDATA;
    logic            PREADY;
    logic            PSLVERR;
    logic [3:0][7:0] padOut;
    logic [3:0][7:0] padOutEn;
    logic [3:0][7:0] padIn;
    logic [3:0][7:0] extLevel;      // Level seen on undriven pins

    logic [3:0][7:0] modeS;         // Expected register contents
    logic [3:0][7:0] dirS;
    logic [3:0][7:0] outS;
    logic [3:0][7:0] extS;
    logic [31:0]     lfsrState;

    tbClockGen uClockGen (
        .PCLK    (PCLK),
        .PRESETn (PRESETn)
    );

    gpioController i_dut (
        .PCLK      (PCLK),
        .PRESETn   (PRESETn),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PSTRB     (PSTRB),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR),
        .padOutA   (padOut[0]),
        .padOutB   (padOut[1]),
        .padOutC   (padOut[2]),
        .padOutD   (padOut[3]),
        .padOutEnA (padOutEn[0]),
        .padOutEnB (padOutEn[1]),
        .padOutEnC (padOutEn[2]),
        .padOutEnD (padOutEn[3]),
        .padInA    (padIn[0]),
        .padInB    (padIn[1]),
        .padInC    (padIn[2]),
        .padInD    (padIn[3])
    );

    bind gpioController gpioController_sva uSva (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PSLVERR     (PSLVERR),
        .padOutAll   (padOutAll),
        .padOutEnAll (padOutEnAll),
        .modeAll     ({genBank[3].uPortBank.modeReg, genBank[2].uPortBank.modeReg,
                       genBank[1].uPortBank.modeReg, genBank[0].uPortBank.modeReg})
    );

    // Pad model, a driven pin reads back its own drive
    assign padIn = (padOutEn & padOut) | (~padOutEn & extLevel);

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value     = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [7:0] padEnable(input int port);
        logic [7:0] en;
        for (int b = 0; b < 8; b++)
        begin
            if (modeS[port][b])
            begin
                en[b] = dirS[port][b] && !outS[port][b];    // Open-drain lets go on a 1
            end
            else
            begin
                en[b] = dirS[port][b];
            end
        end
        return en;
    endfunction

    function automatic logic [7:0] padLevel(input int port);
        logic [7:0] en;
        logic [7:0] level;
        en = padEnable(port);
        for (int b = 0; b < 8; b++)
        begin
            if (!en[b])
            begin
                level[b] = extS[port][b];
            end
            else if (modeS[port][b])
            begin
                level[b] = 1'b0;                            // Pulled low
            end
            else
            begin
                level[b] = outS[port][b];
            end
        end
        return level;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1, "Wait loop ran out of cycles");
    endtask

    task automatic addWrite(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
        opT         op;
        regSelT     sel;
        logic [7:0] lane;
        sel  = regSelT'(addr[1:0]);
        lane = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
            begin
                lane = data[8 * i +: 8];
            end
        end
        op        = '0;
        op.kind   = WR;
        op.addr   = addr;
        op.strb   = strb;
        op.data   = data;
        op.expErr = (addr[15:4] != 12'd0) || (sel == INPUT);
        if (!op.expErr && $onehot(strb))       // Other strobes are ignored
        begin
            case (sel)
                MODE:      modeS[addr[3:2]] = lane;
                DIRECTION: dirS[addr[3:2]]  = lane;
                default:   outS[addr[3:2]]  = lane;
            endcase
        end
        opTable.push_back(op);
    endtask

    task automatic addRead(input logic [31:0] addr);
        opT op;
        int port;
        port      = int'(addr[3:2]);
        op        = '0;
        op.kind   = RD;
        op.addr   = addr;
        op.expErr = (addr[15:4] != 12'd0);
        if (!op.expErr)
        begin
            case (regSelT'(addr[1:0]))
                MODE:      op.expByte = modeS[port];
                DIRECTION: op.expByte = dirS[port];
                OUTPUT:    op.expByte = outS[port];
                default:   op.expByte = padLevel(port);
            endcase
        end
        opTable.push_back(op);
    endtask

    task automatic addExt(input int port, input logic [7:0] level);
        opT op;
        extS[port] = level;
        op         = '0;
        op.kind    = SET_EXT;
        op.addr    = 32'(port);
        op.data    = 32'(level);
        opTable.push_back(op);
    endtask

    task automatic addPadCheck(input int port);
        opT         op;
        logic [7:0] en;
        logic [7:0] care;
        logic [7:0] level;
        en = padEnable(port);
        for (int b = 0; b < 8; b++)
        begin
            if (modeS[port][b])
            begin
                care[b]  = 1'b1;                            // Open-drain never drives high
                level[b] = 1'b0;
            end
            else
            begin
                care[b]  = en[b];
                level[b] = en[b] && outS[port][b];
            end
        end
        op         = '0;
        op.kind    = CHK_PADS;
        op.addr    = 32'(port);
        op.expByte = en;
        op.data    = 32'(care);
        op.expPad  = level;
        opTable.push_back(op);
    endtask

    task automatic addDriveRound(input int port);
        logic [1:0] lane;
        addExt(port, 8'(randBits(8)));
        lane = 2'(randBits(2));
        addWrite(32'(4 * port + 1), 4'b0001 << lane, randBits(32));
        lane = 2'(randBits(2));
        addWrite(32'(4 * port + 2), 4'b0001 << lane, randBits(32));
        addPadCheck(port);
        addRead(32'(4 * port + 3));
    endtask

    task automatic buildTable();
        for (int a = 0; a < 16; a++)
        begin
            addRead(32'(a));
        end
        for (int p = 0; p < 4; p++)
        begin
            for (int r = 0; r < 3; r++)
            begin
                addWrite(32'(4 * p + r), 4'b0001 << ((p + r) % 4), randBits(32));
                addRead(32'(4 * p + r));
            end
        end
        for (int p = 0; p < 4; p++)
        begin
            addWrite(32'(4 * p + 2), 4'b0011, randBits(32));
            addWrite(32'(4 * p + 1), 4'b0000, randBits(32));
            addWrite(32'(4 * p), 4'b1111, randBits(32));
            addRead(32'(4 * p));
            addRead(32'(4 * p + 1));
            addRead(32'(4 * p + 2));
        end
        addRead(32'd16);
        addRead(32'h0000_8003);
        addWrite(32'd16, 4'b0001, randBits(32));
        addWrite(32'h0000_0ff2, 4'b0100, randBits(32));
        addRead(32'hA5A5_0006);                 // PADDR[31:16] not decoded
        for (int p = 0; p < 4; p++)
        begin
            addWrite(32'(4 * p + 3), 4'b0001, randBits(32));
            addRead(32'(4 * p + 3));
            addExt(p, 8'(randBits(8)));
            addRead(32'(4 * p + 3));
        end
        // Push-pull rounds, then open-drain rounds
        for (int m = 0; m < 2; m++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                addWrite(32'(4 * p), 4'b0001, (m == 0) ? 32'h0 : 32'hff);
            end
            for (int round = 0; round < 3; round++)
            begin
                for (int p = 0; p < 4; p++)
                begin
                    addDriveRound(p);
                end
            end
        end
    endtask

    task automatic apbTransfer(input logic write, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [31:0] data,
                               output logic [31:0] rdata, output logic err);
        int waitCount;
        @(posedge PCLK);
        PSEL    <= 1'b1;                        // Setup phase
        PENABLE <= 1'b0;
        PWRITE  <= write;
        PADDR   <= addr;
        PWDATA  <= data;
        PSTRB   <= strb;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        @(negedge PCLK);
        waitCount = 0;
        while (!PREADY)
        begin
            if (waitCount == readyTimeout)
            begin
                reportTimeout("PREADY stayed low in the access phase");
            end
            @(negedge PCLK);
            waitCount++;
        end
        rdata = PRDATA;
        err   = PSLVERR;
        @(posedge PCLK);                        // Transfer completes here
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
        PSTRB   <= 4'b0000;
    endtask

    task automatic applyOp(input opT op);
        logic [31:0] rdata;
        logic        err;
        int          port;
        port = int'(op.addr[1:0]);
        case (op.kind)
            WR, RD:
            begin
                apbTransfer(op.kind == WR, op.addr, op.strb, op.data, rdata, err);
                checkValue("PSLVERR", 32'(err), 32'(op.expErr));
                checkValue("PRDATA", rdata, 32'(op.expByte));
            end
            SET_EXT:
            begin
                @(posedge PCLK);
                extLevel[port] <= op.data[7:0];
            end
            default:
            begin
                @(negedge PCLK);
                checkValue($sformatf("padOutEn[%0d]", port), 32'(padOutEn[port]),
                           32'(op.expByte));
                checkValue($sformatf("padOut[%0d]", port),
                           32'(padOut[port] & op.data[7:0]), 32'(op.expPad));
            end
        endcase
        repeat (idleCycles) @(posedge PCLK);
    endtask

    initial
    begin
        int waitCount;
        PSEL      <= 1'b0;
        PENABLE   <= 1'b0;
        PWRITE    <= 1'b0;
        PADDR     <= '0;
        PWDATA    <= '0;
        PSTRB     <= '0;
        extLevel  <= '0;
        modeS     = '0;
        dirS      = '0;
        outS      = '0;
        extS      = '0;
        lfsrState = 32'he14e_9e5f;
        buildTable();
        waitCount = 0;
        while (PRESETn !== 1'b1)
        begin
            if (waitCount == resetTimeout)
            begin
                reportTimeout("reset was never released");
            end
            @(posedge PCLK);
            waitCount++;
        end
        repeat (2) @(posedge PCLK);
        foreach (opTable[i])
        begin
            applyOp(opTable[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/gpio_pkg.sv
design/apbRegControl.sv
design/gpioPortBank.sv
design/gpioController.sv
sim/tbClockGen.sv
sim/gpioController_sva.sv
sim/gpioController_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the GPIO controller testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

buildDir="obj_dir"
logFile="sim.log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gpioController_tb -f filelist.f \
    --Mdir "$buildDir" -o gpioSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/gpioSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -qx "TEST OK" "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, exit status $simStatus"
    exit 1
fi
